//--- compile.f
logic/ctrl_timing_pkg.sv
logic/status_pkg.sv
logic/lock_monitor.sv
logic/reset_hold_timer.sv
logic/led_glow.sv
logic/status_led_fsm.sv
logic/console_reset_ctrl.sv
sim/console_reset_ctrl_tb.sv

//--- logic/console_reset_ctrl.sv
`timescale 1ns/100ps

module console_reset_ctrl #(
    parameter logic [31:0] hold_cycles = ctrl_timing_pkg::reset_hold_cycles,
    parameter int          slow_bit    = ctrl_timing_pkg::slow_glow_bit,
    parameter int          fast_bit    = ctrl_timing_pkg::fast_glow_bit
) (
    input  logic                       control_clock,
    input  logic                       reset_dc,
    input  logic                       reset_opt,
    input  logic                       pll54_locked_raw,
    input  logic                       hdmi_locked_raw,
    input  status_pkg::video_status_t  video_status,
    input  status_pkg::led_source_e    led_source,
    output logic                       dc_nreset,
    output logic                       opt_nreset,
    output logic                       pll_areset,
    output logic                       status_led,
    output status_pkg::ctrl_status_t   ctrl_status
);

    status_pkg::pll_status_t pll_status;

    logic slow_glow_led;
    logic fast_glow_led;
    logic blink_phase;

    ////////////////////////////////////////////////////////////////////////////
    // pll lock supervision
    ////////////////////////////////////////////////////////////////////////////

    lock_monitor lock_mon (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .pll54_locked_raw (pll54_locked_raw),
        .hdmi_locked_raw  (hdmi_locked_raw),
        .pll_status       (pll_status)
    );

    // single cycle request to the pll reconfig logic
    assign pll_areset = pll_status.lockloss;

    ////////////////////////////////////////////////////////////////////////////
    // reset lines
    ////////////////////////////////////////////////////////////////////////////

    // reset_dc doubles as the console reset request
    reset_hold_timer #(.hold_cycles(hold_cycles)) console_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_dc),
        .nreset        (dc_nreset)
    );

    reset_hold_timer #(.hold_cycles(hold_cycles)) option_hold (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .request       (reset_opt),
        .nreset        (opt_nreset)
    );

    ////////////////////////////////////////////////////////////////////////////
    // led patterns
    ////////////////////////////////////////////////////////////////////////////

    led_glow #(.top_bit(slow_bit)) slow_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (slow_glow_led),
        .blink_phase   ()
    );

    led_glow #(.top_bit(fast_bit)) fast_glow (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .glow          (fast_glow_led),
        .blink_phase   (blink_phase)
    );

    status_led_fsm led_fsm (
        .control_clock (control_clock),
        .reset_dc      (reset_dc),
        .video_status  (video_status),
        .pll_status    (pll_status),
        .led_source    (led_source),
        .dc_nreset     (dc_nreset),
        .opt_nreset    (opt_nreset),
        .slow_glow     (slow_glow_led),
        .fast_glow     (fast_glow_led),
        .blink_phase   (blink_phase),
        .status_led    (status_led),
        .ctrl_status   (ctrl_status)
    );

endmodule

//--- logic/ctrl_timing_pkg.sv
package ctrl_timing_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // reset hold
    ////////////////////////////////////////////////////////////////////////////

    // cycles a console or optional reset stays asserted after a request
    localparam logic [31:0] reset_hold_cycles = 32'd32_000_000;

    ////////////////////////////////////////////////////////////////////////////
    // led glow
    ////////////////////////////////////////////////////////////////////////////

    // top counter bit of the slow fade, roughly one breath per second
    localparam int slow_glow_bit = 26;

    // top counter bit of the fast fade, used for resync and test pattern
    localparam int fast_glow_bit = 22;

    // width of the pwm ramp and of the folded brightness word
    localparam int glow_pwm_bits = 4;

    ////////////////////////////////////////////////////////////////////////////
    // clock domain crossing
    ////////////////////////////////////////////////////////////////////////////

    // flops in each lock flag synchronizer
    localparam int sync_stages = 2;

endpackage

//--- logic/led_glow.sv
`timescale 1ns/100ps

module led_glow #(
    parameter int top_bit = ctrl_timing_pkg::slow_glow_bit
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow,
    output logic blink_phase
);

    localparam int pwm_bits = ctrl_timing_pkg::glow_pwm_bits;

    logic [top_bit:0]    counter;
    logic [pwm_bits-1:0] ramp;
    logic [pwm_bits-1:0] brightness;

    // fast low bits give the pwm carrier
    assign ramp = counter[pwm_bits-1:0];

    // upper bits folded so the brightness climbs then falls back
    assign brightness = counter[top_bit] ? counter[top_bit-1 -: pwm_bits]
                                         : ~counter[top_bit-1 -: pwm_bits];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            counter <= '0;
            glow    <= 1'b0;
        end else begin
            counter <= counter + 1'b1;
            glow    <= (ramp < brightness);
        end
    end

    // half period flag, also used for blinking
    assign blink_phase = counter[top_bit];

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // the status fsm and the testbench derive blink_phase from a cycle count
    counter_free_running: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        !$past(reset_dc) |-> counter == $past(counter) + 1'b1
    ) else $error("glow counter skipped or stalled");

endmodule

//--- logic/lock_monitor.sv
`timescale 1ns/100ps

module lock_monitor (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  logic                     pll54_locked_raw,
    input  logic                     hdmi_locked_raw,
    output status_pkg::pll_status_t  pll_status
);

    localparam int stages = ctrl_timing_pkg::sync_stages;

    // synchronizer chains, bit 0 samples the raw flag
    logic [stages-1:0] pll54_sync;
    logic [stages-1:0] hdmi_sync;

    // synchronized levels one cycle back
    logic pll54_prev;
    logic hdmi_prev;

    logic lockloss_q;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pll54_sync <= '0;
            hdmi_sync  <= '0;
            pll54_prev <= 1'b0;
            hdmi_prev  <= 1'b0;
            lockloss_q <= 1'b0;
        end else begin
            pll54_sync <= {pll54_sync[stages-2:0], pll54_locked_raw};
            hdmi_sync  <= {hdmi_sync[stages-2:0], hdmi_locked_raw};
            pll54_prev <= pll54_sync[stages-1];
            hdmi_prev  <= hdmi_sync[stages-1];
            // falling edge of either lock, a rising lock never counts
            lockloss_q <= (pll54_prev && !pll54_sync[stages-1])
                       || (hdmi_prev && !hdmi_sync[stages-1]);
        end
    end

    assign pll_status.pll54_locked = pll54_sync[stages-1];
    assign pll_status.hdmi_locked  = hdmi_sync[stages-1];
    assign pll_status.lockloss     = lockloss_q;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // pll reconfig logic expects a single cycle reset request
    lockloss_single_pulse: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        lockloss_q |=> !lockloss_q
    ) else $error("lockloss held high for more than one cycle");

endmodule

//--- logic/reset_hold_timer.sv
`timescale 1ns/100ps

module reset_hold_timer #(
    parameter logic [31:0] hold_cycles = ctrl_timing_pkg::reset_hold_cycles
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic nreset
);

    // saturating hold counter
    logic [31:0] count;

    // request wins over reset_dc so that a line wired to reset_dc
    // starts its hold right away, any other line is forced done
    always_ff @(posedge control_clock) begin
        if (request) begin
            count  <= '0;
            nreset <= 1'b0;
        end else if (reset_dc) begin
            count  <= hold_cycles;
            nreset <= 1'b1;
        end else begin
            if (count != hold_cycles) begin
                count <= count + 32'd1;
            end
            // released once the old count has reached the hold time
            if (count == hold_cycles) begin
                nreset <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // the console must only see a reset that somebody asked for
    nreset_needs_request: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        $fell(nreset) |-> $past(request)
    ) else $error("nreset fell without a request");

endmodule

//--- logic/status_led_fsm.sv
`timescale 1ns/100ps

module status_led_fsm (
    input  logic                       control_clock,
    input  logic                       reset_dc,
    input  status_pkg::video_status_t  video_status,
    input  status_pkg::pll_status_t    pll_status,
    input  status_pkg::led_source_e    led_source,
    input  logic                       dc_nreset,
    input  logic                       opt_nreset,
    input  logic                       slow_glow,
    input  logic                       fast_glow,
    input  logic                       blink_phase,
    output logic                       status_led,
    output status_pkg::ctrl_status_t   ctrl_status
);

    status_pkg::led_state_e state;
    status_pkg::led_state_e next_state;

    // pattern for the current state, led is active low
    logic status_pattern;

    ////////////////////////////////////////////////////////////////////////////
    // state selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (!pll_status.hdmi_locked) begin
            next_state = status_pkg::pll_wait;
        end else if (video_status.resync) begin
            next_state = status_pkg::signal_resync;
        end else if (video_status.force_generate) begin
            next_state = status_pkg::generating;
        end else if (!video_status.hdmi_ready) begin
            next_state = status_pkg::hdmi_init;
        end else begin
            next_state = status_pkg::running;
        end
    end

    always_comb begin
        case (state)
            status_pkg::pll_wait: begin
                status_pattern = 1'b1;
            end
            status_pkg::signal_resync: begin
                status_pattern = ~fast_glow;
            end
            // fast fade on every other blink phase
            status_pkg::generating: begin
                status_pattern = blink_phase ? ~fast_glow : 1'b1;
            end
            status_pkg::hdmi_init: begin
                status_pattern = ~slow_glow;
            end
            status_pkg::running: begin
                status_pattern = 1'b0;
            end
            default: begin
                status_pattern = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            state      <= status_pkg::pll_wait;
            status_led <= 1'b1;
        end else begin
            state <= next_state;
            case (led_source)
                status_pkg::show_status: status_led <= status_pattern;
                status_pkg::mirror_dc:   status_led <= dc_nreset;
                // unused code falls back to the optional line
                default:                 status_led <= opt_nreset;
            endcase
        end
    end

    // host status word
    always_comb begin
        ctrl_status.state        = state;
        ctrl_status.pll54_locked = pll_status.pll54_locked;
        ctrl_status.hdmi_locked  = pll_status.hdmi_locked;
        ctrl_status.dc_in_reset  = ~dc_nreset;
        ctrl_status.opt_in_reset = ~opt_nreset;
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // a working video path must show a steady lit led
    running_led_on: assert property (
        @(posedge control_clock) disable iff (reset_dc)
        (state == status_pkg::running && led_source == status_pkg::show_status)
            |=> !status_led
    ) else $error("status led not lit in running state");

endmodule

//--- logic/status_pkg.sv
package status_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // led state and source selection
    ////////////////////////////////////////////////////////////////////////////

    // listed in order of falling priority
    typedef enum logic [2:0] {
        pll_wait      = 3'd0,
        signal_resync = 3'd1,
        generating    = 3'd2,
        hdmi_init     = 3'd3,
        running       = 3'd4
    } led_state_e;

    // host selected led source, code 3 behaves as mirror_opt
    typedef enum logic [1:0] {
        show_status = 2'd0,
        mirror_dc   = 2'd1,
        mirror_opt  = 2'd2
    } led_source_e;

    ////////////////////////////////////////////////////////////////////////////
    // status words
    ////////////////////////////////////////////////////////////////////////////

    // levels from the video paths and the hdmi transmitter setup
    typedef struct packed {
        logic resync;
        logic force_generate;
        logic hdmi_ready;
    } video_status_t;

    // lock levels already on control_clock, lockloss is a single pulse
    typedef struct packed {
        logic pll54_locked;
        logic hdmi_locked;
        logic lockloss;
    } pll_status_t;

    // read back by the host
    typedef struct packed {
        led_state_e state;
        logic       pll54_locked;
        logic       hdmi_locked;
        logic       dc_in_reset;
        logic       opt_in_reset;
    } ctrl_status_t;

endpackage

//--- run_sim.sh
#!/bin/sh
# build and run the console reset controller testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
build=obj_dir

verilator --binary --timing --assert -Wno-fatal \
    --top-module console_reset_ctrl_tb -Mdir "$build" -o console_reset_ctrl_sim \
    -f compile.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build/console_reset_ctrl_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log"; then
    exit 1
fi
exit 0

//--- sim/console_reset_ctrl_tb.sv
`timescale 1ns/100ps

module console_reset_ctrl_tb;

    localparam int hold = 40;
    localparam int release_edges = hold + 1;
    localparam int slow_bit = 8;
    localparam int fast_bit = 5;
    localparam int stages = ctrl_timing_pkg::sync_stages;
    localparam int hist_bits = stages + 2;
    localparam int resync_window = 64;
    // tests take a little under 2000 cycles
    localparam int max_cycles = 4000;

    logic                       control_clock;
    logic                       reset_dc;
    logic                       reset_opt;
    logic                       pll54_locked_raw;
    logic                       hdmi_locked_raw;
    status_pkg::video_status_t  video_status;
    status_pkg::led_source_e    led_source;
    logic                       dc_nreset;
    logic                       opt_nreset;
    logic                       pll_areset;
    logic                       status_led;
    status_pkg::ctrl_status_t   ctrl_status;

    integer seed;
    int     errors = 0;
    int     errors_at_start = 0;
    int     test_num = 0;
    int     cycle_count = 0;

    // reference counters advanced on the same edges as the DUT
    int                   dc_edges;
    int                   opt_edges;
    int                   glow_cycles;
    int                   still_cycles;
    logic                 prev_led;
    logic [hist_bits-1:0] pll54_hist;
    logic [hist_bits-1:0] hdmi_hist;

    status_pkg::led_state_e expected_state;
    logic                   expected_areset;

    console_reset_ctrl #(
        .hold_cycles (32'd40),
        .slow_bit    (slow_bit),
        .fast_bit    (fast_bit)
    ) uut (
        .control_clock    (control_clock),
        .reset_dc         (reset_dc),
        .reset_opt        (reset_opt),
        .pll54_locked_raw (pll54_locked_raw),
        .hdmi_locked_raw  (hdmi_locked_raw),
        .video_status     (video_status),
        .led_source       (led_source),
        .dc_nreset        (dc_nreset),
        .opt_nreset       (opt_nreset),
        .pll_areset       (pll_areset),
        .status_led       (status_led),
        .ctrl_status      (ctrl_status)
    );

    initial begin
        control_clock = 1'b0;
        forever #2 control_clock = ~control_clock;
    end

    ////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////

    function automatic status_pkg::led_state_e priority_state(
        input status_pkg::video_status_t v,
        input logic                      locked
    );
        if (!locked) begin
            return status_pkg::pll_wait;
        end else if (v.resync) begin
            return status_pkg::signal_resync;
        end else if (v.force_generate) begin
            return status_pkg::generating;
        end else if (!v.hdmi_ready) begin
            return status_pkg::hdmi_init;
        end
        return status_pkg::running;
    endfunction

    always_comb begin
        expected_state = priority_state(video_status, hdmi_hist[stages-1]);
        // falling synchronized level seen one cycle late
        expected_areset = (pll54_hist[stages+1] && !pll54_hist[stages])
                       || (hdmi_hist[stages+1] && !hdmi_hist[stages]);
    end

    always @(posedge control_clock) begin
        if (reset_dc) begin
            dc_edges     <= 0;
            opt_edges    <= release_edges;
            glow_cycles  <= 0;
            still_cycles <= 0;
            prev_led     <= 1'b1;
            pll54_hist   <= '0;
            hdmi_hist    <= '0;
        end else begin
            if (dc_edges < release_edges) begin
                dc_edges <= dc_edges + 1;
            end
            if (reset_opt) begin
                opt_edges <= 0;
            end else if (opt_edges < release_edges) begin
                opt_edges <= opt_edges + 1;
            end
            glow_cycles <= glow_cycles + 1;
            pll54_hist  <= {pll54_hist[hist_bits-2:0], pll54_locked_raw};
            hdmi_hist   <= {hdmi_hist[hist_bits-2:0], hdmi_locked_raw};
            if (status_led != prev_led || ctrl_status.state != status_pkg::signal_resync
                    || led_source != status_pkg::show_status) begin
                still_cycles <= 0;
            end else begin
                still_cycles <= still_cycles + 1;
            end
            prev_led <= status_led;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    dc_hold_time: assert property (@(posedge control_clock) disable iff (reset_dc)
        dc_nreset == (dc_edges >= release_edges)
    ) else report_error("dc_nreset differs from the hold time");

    opt_hold_time: assert property (@(posedge control_clock) disable iff (reset_dc)
        opt_nreset == (opt_edges >= release_edges)
    ) else report_error("opt_nreset differs from the hold time");

    reset_flags: assert property (@(posedge control_clock) disable iff (reset_dc)
        ctrl_status.dc_in_reset == (dc_edges < release_edges)
            && ctrl_status.opt_in_reset == (opt_edges < release_edges)
    ) else report_error("reset flags in ctrl_status differ from the hold time");

    dc_mirror: assert property (@(posedge control_clock) disable iff (reset_dc)
        led_source == status_pkg::mirror_dc |=> status_led == $past(dc_nreset)
    ) else report_error("status_led does not mirror dc_nreset");

    opt_mirror: assert property (@(posedge control_clock) disable iff (reset_dc)
        led_source == status_pkg::mirror_opt |=> status_led == $past(opt_nreset)
    ) else report_error("status_led does not mirror opt_nreset");

    state_priority: assert property (@(posedge control_clock) disable iff (reset_dc)
        1'b1 |=> ctrl_status.state == $past(expected_state)
    ) else report_error("state does not follow the flag priority");

    wait_led_off: assert property (@(posedge control_clock) disable iff (reset_dc)
        (ctrl_status.state == status_pkg::pll_wait && led_source == status_pkg::show_status)
            |=> status_led
    ) else report_error("status_led not off in pll_wait");

    running_led_lit: assert property (@(posedge control_clock) disable iff (reset_dc)
        (ctrl_status.state == status_pkg::running && led_source == status_pkg::show_status)
            |=> !status_led
    ) else report_error("status_led not lit in running");

    resync_toggles: assert property (@(posedge control_clock) disable iff (reset_dc)
        still_cycles < resync_window
    ) else report_error("status_led stuck during signal_resync");

    // blink_phase is the top bit of the fast glow counter
    generate_dark_phase: assert property (@(posedge control_clock) disable iff (reset_dc)
        (ctrl_status.state == status_pkg::generating && led_source == status_pkg::show_status
            && !glow_cycles[fast_bit]) |=> status_led
    ) else report_error("status_led lit in the dark generating phase");

    lock_flags: assert property (@(posedge control_clock) disable iff (reset_dc)
        ctrl_status.pll54_locked == pll54_hist[stages-1]
            && ctrl_status.hdmi_locked == hdmi_hist[stages-1]
    ) else report_error("synchronized lock flags out of step");

    areset_pulse: assert property (@(posedge control_clock) disable iff (reset_dc)
        pll_areset == expected_areset
    ) else report_error("pll_areset does not match the lock loss");

    ////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////

    function automatic int random_gap();
        random_gap = 4 + ($unsigned($random(seed)) % 16);
    endfunction

    task automatic run_cycles(input int n);
        repeat (n) @(posedge control_clock);
    endtask

    task automatic wait_state(input status_pkg::led_state_e s);
        while (ctrl_status.state != s) @(posedge control_clock);
    endtask

    task automatic close_test(input string name);
        test_num++;
        $display("test %0d %s: %0d errors", test_num, name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    always @(posedge control_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run did not end within %0d cycles", max_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        seed = 1894;
        reset_dc = 1'b1;
        reset_opt = 1'b0;
        pll54_locked_raw = 1'b0;
        hdmi_locked_raw = 1'b0;
        video_status = '0;
        led_source = status_pkg::mirror_dc;
        run_cycles(8);
        reset_dc <= 1'b0;

        while (!dc_nreset) @(posedge control_clock);
        run_cycles(random_gap());
        close_test("console hold with dc mirror");

        led_source <= status_pkg::mirror_opt;
        run_cycles(random_gap());
        reset_opt <= 1'b1;
        run_cycles(random_gap());
        reset_opt <= 1'b0;
        @(posedge control_clock);
        while (!opt_nreset) @(posedge control_clock);
        run_cycles(random_gap());
        close_test("optional reset with opt mirror");

        led_source <= status_pkg::show_status;
        run_cycles(random_gap());
        pll54_locked_raw <= 1'b1;
        hdmi_locked_raw <= 1'b1;
        video_status.hdmi_ready <= 1'b1;
        wait_state(status_pkg::running);
        run_cycles(random_gap());
        video_status.hdmi_ready <= 1'b0;
        wait_state(status_pkg::hdmi_init);
        run_cycles(random_gap());
        close_test("status priority");

        video_status.resync <= 1'b1;
        wait_state(status_pkg::signal_resync);
        run_cycles(10 * resync_window);
        video_status.resync <= 1'b0;
        video_status.force_generate <= 1'b1;
        wait_state(status_pkg::generating);
        run_cycles(10 * (2 << fast_bit));
        close_test("led patterns");

        video_status.force_generate <= 1'b0;
        video_status.hdmi_ready <= 1'b1;
        wait_state(status_pkg::running);
        pll54_locked_raw <= 1'b0;
        run_cycles(random_gap());
        pll54_locked_raw <= 1'b1;
        run_cycles(random_gap());
        hdmi_locked_raw <= 1'b0;
        run_cycles(random_gap());
        hdmi_locked_raw <= 1'b1;
        wait_state(status_pkg::running);
        run_cycles(random_gap());
        close_test("lock loss");

        $display("tests run: %0d, checks failed: %0d", test_num, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
